// ==== design/rv_pkg.sv ====
package rv_pkg;

    // Base opcodes, instr[6:0]
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_src_e;

    typedef enum logic [1:0] {
        ALU_OP_ADDR   = 2'b00,  // Address and link adds
        ALU_OP_BRANCH = 2'b01,  // Compare picked by funct3
        ALU_OP_ARITH  = 2'b10,  // R-type or I-type arithmetic
        ALU_OP_PASS_B = 2'b11   // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } result_src_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_ctrl_e;

endpackage

// ==== design/main_decoder.sv ====
`timescale 1ns/1ps

module main_decoder (
    input  logic [6:0]          op_i,          // Instruction opcode

    output rv_pkg::result_src_e result_src_o,  // Value written back to rd
    output logic                mem_write_o,   // Memory write enable
    output logic                alu_src_o,     // 1 selects immediate as operand B
    output rv_pkg::imm_src_e    imm_src_o,     // Immediate format
    output logic                reg_write_o,   // Register file write enable
    output rv_pkg::alu_op_e     alu_op_o,      // Class for the ALU decoder
    output logic                branch_o,      // Conditional branch
    output logic                jump_o,        // JAL or JALR
    output logic                jalr_o,        // Target from rs1 + imm
    output logic                pc_alu_a_o,    // PC as operand A
    output logic                illegal_o      // Opcode not supported
);

    always_comb
    begin
        // Safe values, every enable low
        reg_write_o  = 1'b0;
        mem_write_o  = 1'b0;
        alu_src_o    = 1'b0;
        imm_src_o    = rv_pkg::IMM_I;
        result_src_o = rv_pkg::RES_ALU;
        alu_op_o     = rv_pkg::ALU_OP_ADDR;
        branch_o     = 1'b0;
        jump_o       = 1'b0;
        jalr_o       = 1'b0;
        pc_alu_a_o   = 1'b0;
        illegal_o    = 1'b0;

        case (op_i)
            rv_pkg::OPC_LOAD:
            begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = rv_pkg::RES_MEM;
            end
            rv_pkg::OPC_STORE:
            begin
                mem_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = rv_pkg::IMM_S;
            end
            rv_pkg::OPC_OP:
            begin
                reg_write_o = 1'b1;
                alu_op_o    = rv_pkg::ALU_OP_ARITH;  // Immediate unused
            end
            rv_pkg::OPC_OP_IMM:
            begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                alu_op_o    = rv_pkg::ALU_OP_ARITH;
            end
            rv_pkg::OPC_BRANCH:
            begin
                imm_src_o = rv_pkg::IMM_B;
                alu_op_o  = rv_pkg::ALU_OP_BRANCH;
                branch_o  = 1'b1;
            end
            rv_pkg::OPC_JAL:
            begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;
                imm_src_o    = rv_pkg::IMM_J;
                result_src_o = rv_pkg::RES_PC4;  // Link address
                jump_o       = 1'b1;
            end
            rv_pkg::OPC_JALR:
            begin
                reg_write_o  = 1'b1;
                alu_src_o    = 1'b1;
                result_src_o = rv_pkg::RES_PC4;
                jump_o       = 1'b1;
                jalr_o       = 1'b1;
            end
            rv_pkg::OPC_AUIPC:
            begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = rv_pkg::IMM_U;
                pc_alu_a_o  = 1'b1;  // PC + upper immediate
            end
            rv_pkg::OPC_LUI:
            begin
                reg_write_o = 1'b1;
                alu_src_o   = 1'b1;
                imm_src_o   = rv_pkg::IMM_U;
                alu_op_o    = rv_pkg::ALU_OP_PASS_B;
            end
            default:
            begin
                illegal_o = 1'b1;  // FENCE, SYSTEM and unknown
            end
        endcase

        // A store never writes back, a jump is never also a branch
        assert (!(mem_write_o && reg_write_o))
            else $error("main_decoder: mem_write and reg_write both high");
        assert (!(branch_o && jump_o))
            else $error("main_decoder: branch and jump both high");
    end

endmodule

// ==== design/alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder (
    input  rv_pkg::alu_op_e   alu_op_i,     // Class from the main decoder
    input  logic [2:0]        funct3_i,
    input  logic              funct7_b5_i,  // instr[30]
    input  logic              op_b5_i,      // 1 for R-type, 0 for I-type

    output rv_pkg::alu_ctrl_e alu_ctrl_o
);

    logic sub_en;

    // ADDI has no SUB form, bit 30 is part of its immediate
    assign sub_en = funct7_b5_i & op_b5_i;

    always_comb
    begin
        alu_ctrl_o = rv_pkg::ALU_ADD;

        case (alu_op_i)
            rv_pkg::ALU_OP_ADDR:
            begin
                alu_ctrl_o = rv_pkg::ALU_ADD;
            end
            rv_pkg::ALU_OP_BRANCH:
            begin
                case (funct3_i)
                    3'd0, 3'd1: alu_ctrl_o = rv_pkg::ALU_SUB;   // BEQ, BNE
                    3'd4, 3'd5: alu_ctrl_o = rv_pkg::ALU_SLT;   // BLT, BGE
                    3'd6, 3'd7: alu_ctrl_o = rv_pkg::ALU_SLTU;  // BLTU, BGEU
                    default:    alu_ctrl_o = rv_pkg::ALU_ADD;
                endcase
            end
            rv_pkg::ALU_OP_ARITH:
            begin
                case (funct3_i)
                    3'd0: alu_ctrl_o = sub_en ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'd1: alu_ctrl_o = rv_pkg::ALU_SLL;
                    3'd2: alu_ctrl_o = rv_pkg::ALU_SLT;
                    3'd3: alu_ctrl_o = rv_pkg::ALU_SLTU;
                    3'd4: alu_ctrl_o = rv_pkg::ALU_XOR;
                    3'd5: alu_ctrl_o = funct7_b5_i ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'd6: alu_ctrl_o = rv_pkg::ALU_OR;
                    default: alu_ctrl_o = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::ALU_OP_PASS_B:
            begin
                alu_ctrl_o = rv_pkg::ALU_PASS_B;  // LUI forwards the immediate
            end
            default:
            begin
                alu_ctrl_o = rv_pkg::ALU_ADD;
            end
        endcase
    end

endmodule

// ==== design/imm_extend.sv ====
`timescale 1ns/1ps

module imm_extend #(
    parameter int XLEN = 32
) (
    input  logic [31:0]      instr_i,
    input  rv_pkg::imm_src_e imm_src_i,

    output logic [XLEN-1:0]  imm_o
);

    // Every format keeps its sign in instr[31]
    if (XLEN < 32)
    begin : g_xlen_check
        $error("imm_extend: XLEN must be at least 32");
    end

    always_comb
    begin
        case (imm_src_i)
            rv_pkg::IMM_I:
            begin
                imm_o = XLEN'($signed(instr_i[31:20]));
            end
            rv_pkg::IMM_S:
            begin
                imm_o = XLEN'($signed({instr_i[31:25], instr_i[11:7]}));
            end
            rv_pkg::IMM_B:
            begin
                imm_o = XLEN'($signed({instr_i[31], instr_i[7], instr_i[30:25],
                                       instr_i[11:8], 1'b0}));  // Halfword offset
            end
            rv_pkg::IMM_J:
            begin
                imm_o = XLEN'($signed({instr_i[31], instr_i[19:12], instr_i[20],
                                       instr_i[30:21], 1'b0}));
            end
            rv_pkg::IMM_U:
            begin
                // Only extends when XLEN is wider than 32
                imm_o = XLEN'($signed({instr_i[31:12], 12'b0}));
            end
            default:
            begin
                imm_o = '0;
            end
        endcase
    end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage #(
    parameter int XLEN = 32
) (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                instr_valid_i,  // One strobe per instruction
    input  logic [31:0]         instr_i,

    output logic                ctrl_valid_o,
    output logic                reg_write_o,
    output logic                mem_write_o,
    output logic                alu_src_o,
    output rv_pkg::result_src_e result_src_o,
    output logic                branch_o,
    output logic                jump_o,
    output logic                jalr_o,
    output logic                pc_alu_a_o,
    output logic                illegal_o,
    output rv_pkg::alu_ctrl_e   alu_ctrl_o,
    output logic [2:0]          branch_funct3_o,  // Compare kind for EX
    output logic [4:0]          rd_o,
    output logic [4:0]          rs1_o,
    output logic [4:0]          rs2_o,
    output logic [XLEN-1:0]     imm_o
);

    rv_pkg::result_src_e result_src;
    rv_pkg::imm_src_e    imm_src;
    rv_pkg::alu_op_e     alu_op;
    rv_pkg::alu_ctrl_e   alu_ctrl;
    logic                mem_write, alu_src, reg_write;
    logic                branch, jump, jalr, pc_alu_a, illegal;
    logic [XLEN-1:0]     imm;

    main_decoder i_main_decoder (
        .op_i         (instr_i[6:0]),
        .result_src_o (result_src),
        .mem_write_o  (mem_write),
        .alu_src_o    (alu_src),
        .imm_src_o    (imm_src),
        .reg_write_o  (reg_write),
        .alu_op_o     (alu_op),
        .branch_o     (branch),
        .jump_o       (jump),
        .jalr_o       (jalr),
        .pc_alu_a_o   (pc_alu_a),
        .illegal_o    (illegal)
    );

    alu_decoder i_alu_decoder (
        .alu_op_i    (alu_op),
        .funct3_i    (instr_i[14:12]),
        .funct7_b5_i (instr_i[30]),
        .op_b5_i     (instr_i[5]),
        .alu_ctrl_o  (alu_ctrl)
    );

    imm_extend #(
        .XLEN (XLEN)
    ) i_imm_extend (
        .instr_i   (instr_i),
        .imm_src_i (imm_src),
        .imm_o     (imm)
    );

    // ID/EX control, enables forced low on idle cycles
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ctrl_valid_o <= 1'b0;
            reg_write_o  <= 1'b0;
            mem_write_o  <= 1'b0;
            branch_o     <= 1'b0;
            jump_o       <= 1'b0;
            jalr_o       <= 1'b0;
            illegal_o    <= 1'b0;
        end
        else
        begin
            ctrl_valid_o <= instr_valid_i;
            reg_write_o  <= instr_valid_i & reg_write;
            mem_write_o  <= instr_valid_i & mem_write;
            branch_o     <= instr_valid_i & branch;
            jump_o       <= instr_valid_i & jump;
            jalr_o       <= instr_valid_i & jalr;
            if (instr_valid_i)
            begin
                illegal_o <= illegal;  // Holds like the data fields
            end
        end
    end

    // ID/EX payload, loaded only with a valid instruction
    always_ff @(posedge clk_i)
    begin
        if (instr_valid_i)
        begin
            alu_src_o       <= alu_src;
            result_src_o    <= result_src;
            pc_alu_a_o      <= pc_alu_a;
            alu_ctrl_o      <= alu_ctrl;
            branch_funct3_o <= instr_i[14:12];
            rd_o            <= instr_i[11:7];
            rs1_o           <= instr_i[19:15];
            rs2_o           <= instr_i[24:20];
            imm_o           <= imm;
        end
    end

    a_valid_follows: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $past(arst_n_i) |-> ctrl_valid_o == $past(instr_valid_i))
        else $error("decode_stage: ctrl_valid_o does not follow instr_valid_i");

    a_no_write_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !ctrl_valid_o |-> !(reg_write_o || mem_write_o))
        else $error("decode_stage: write enable high without ctrl_valid_o");

endmodule

// ==== dv/decode_stage_tb.sv ====
`timescale 1ns/1ps

module decode_stage_tb;

    localparam int XLEN       = 32;
    localparam int CLK_PERIOD = 20;
    localparam int RST_CYCLES = 10;
    localparam int NUM_TESTS  = 4000;
    localparam int WATCHDOG   = (NUM_TESTS + RST_CYCLES + 50) * CLK_PERIOD;

    typedef struct packed {
        logic       reg_write;
        logic       mem_write;
        logic       alu_src;
        logic [2:0] imm_src;
        logic [1:0] result_src;
        logic [1:0] alu_op;
        logic       branch;
        logic       jump;
        logic       jalr;
        logic       pc_alu_a;
        logic       illegal;
    } ctrl_t;

    logic                clk_i;
    logic                arst_n_i;
    logic                instr_valid_i;
    logic [31:0]         instr_i;
    logic                ctrl_valid_o, reg_write_o, mem_write_o, alu_src_o;
    logic                branch_o, jump_o, jalr_o, pc_alu_a_o, illegal_o;
    rv_pkg::result_src_e result_src_o;
    rv_pkg::alu_ctrl_e   alu_ctrl_o;
    logic [2:0]          branch_funct3_o;
    logic [4:0]          rd_o, rs1_o, rs2_o;
    logic [XLEN-1:0]     imm_o;

    logic [31:0]         lfsr_state;
    logic                last_illegal;  // illegal_o holds through idle cycles
    logic [31:0]         instr_q[$];
    logic                valid_q[$];

    decode_stage #(
        .XLEN (XLEN)
    ) i_dut (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // Row order: reg_write mem_write alu_src, imm_src, result_src, alu_op,
    // branch jump jalr pc_alu_a illegal
    function automatic ctrl_t control_row(input logic [6:0] op);
        ctrl_t row;
        case (op)
            rv_pkg::OPC_LOAD:
                row = {3'b101, rv_pkg::IMM_I, rv_pkg::RES_MEM, rv_pkg::ALU_OP_ADDR, 5'b00000};
            rv_pkg::OPC_STORE:
                row = {3'b011, rv_pkg::IMM_S, rv_pkg::RES_ALU, rv_pkg::ALU_OP_ADDR, 5'b00000};
            rv_pkg::OPC_OP:
                row = {3'b100, rv_pkg::IMM_I, rv_pkg::RES_ALU, rv_pkg::ALU_OP_ARITH, 5'b00000};
            rv_pkg::OPC_OP_IMM:
                row = {3'b101, rv_pkg::IMM_I, rv_pkg::RES_ALU, rv_pkg::ALU_OP_ARITH, 5'b00000};
            rv_pkg::OPC_BRANCH:
                row = {3'b000, rv_pkg::IMM_B, rv_pkg::RES_ALU, rv_pkg::ALU_OP_BRANCH, 5'b10000};
            rv_pkg::OPC_JAL:
                row = {3'b101, rv_pkg::IMM_J, rv_pkg::RES_PC4, rv_pkg::ALU_OP_ADDR, 5'b01000};
            rv_pkg::OPC_JALR:
                row = {3'b101, rv_pkg::IMM_I, rv_pkg::RES_PC4, rv_pkg::ALU_OP_ADDR, 5'b01100};
            rv_pkg::OPC_AUIPC:
                row = {3'b101, rv_pkg::IMM_U, rv_pkg::RES_ALU, rv_pkg::ALU_OP_ADDR, 5'b00010};
            rv_pkg::OPC_LUI:
                row = {3'b101, rv_pkg::IMM_U, rv_pkg::RES_ALU, rv_pkg::ALU_OP_PASS_B, 5'b00000};
            default:
                row = {3'b000, rv_pkg::IMM_I, rv_pkg::RES_ALU, rv_pkg::ALU_OP_ADDR, 5'b00001};
        endcase
        return row;
    endfunction

    function automatic logic [3:0] alu_model(input logic [1:0] alu_op, input logic [2:0] f3,
                                             input logic f7_b5, input logic r_type);
        logic [3:0] ctrl;
        ctrl = rv_pkg::ALU_ADD;
        case (alu_op)
            rv_pkg::ALU_OP_BRANCH:
            begin
                if (f3[2:1] == 2'b00)
                    ctrl = rv_pkg::ALU_SUB;
                else if (f3[2:1] == 2'b10)
                    ctrl = rv_pkg::ALU_SLT;
                else if (f3[2:1] == 2'b11)
                    ctrl = rv_pkg::ALU_SLTU;
            end
            rv_pkg::ALU_OP_ARITH:
            begin
                case (f3)
                    3'd0: ctrl = (f7_b5 && r_type) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                    3'd1: ctrl = rv_pkg::ALU_SLL;
                    3'd2: ctrl = rv_pkg::ALU_SLT;
                    3'd3: ctrl = rv_pkg::ALU_SLTU;
                    3'd4: ctrl = rv_pkg::ALU_XOR;
                    3'd5: ctrl = f7_b5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                    3'd6: ctrl = rv_pkg::ALU_OR;
                    default: ctrl = rv_pkg::ALU_AND;
                endcase
            end
            rv_pkg::ALU_OP_PASS_B: ctrl = rv_pkg::ALU_PASS_B;
            default: ctrl = rv_pkg::ALU_ADD;
        endcase
        return ctrl;
    endfunction

    function automatic logic [31:0] imm_model(input logic [2:0] imm_src, input logic [31:0] w);
        logic [31:0] imm;
        case (imm_src)
            rv_pkg::IMM_S: imm = {{20{w[31]}}, w[31:25], w[11:7]};
            rv_pkg::IMM_B: imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            rv_pkg::IMM_J: imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            rv_pkg::IMM_U: imm = {w[31:12], 12'h000};
            default:       imm = {{20{w[31]}}, w[31:20]};
        endcase
        return imm;
    endfunction

    function automatic logic [6:0] legal_opcode(input logic [3:0] idx);
        case (idx)
            4'd0: return rv_pkg::OPC_LOAD;
            4'd1: return rv_pkg::OPC_STORE;
            4'd2: return rv_pkg::OPC_OP;
            4'd3: return rv_pkg::OPC_OP_IMM;
            4'd4: return rv_pkg::OPC_BRANCH;
            4'd5: return rv_pkg::OPC_JAL;
            4'd6: return rv_pkg::OPC_JALR;
            4'd7: return rv_pkg::OPC_AUIPC;
            default: return rv_pkg::OPC_LUI;
        endcase
    endfunction

    task automatic make_instr(output logic [31:0] instr, output logic valid);
        logic [31:0] r;
        logic [6:0]  op;
        ctrl_t       row;
        r = take_bits(4);
        if (r[3:0] == 4'hf)
        begin
            r   = take_bits(7);
            op  = r[6:0];
            row = control_row(op);
            if (!row.illegal)
                op = 7'b1110011;  // SYSTEM
        end
        else
        begin
            op = legal_opcode(r[3:0] % 4'd9);
        end
        r     = take_bits(25);
        instr = {r[24:0], op};
        r     = take_bits(2);
        valid = (r[1:0] != 2'b00);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic check_idle(input string tag, input logic exp_illegal);
        check_value({tag, " ctrl_valid"}, 32'd0, 32'(ctrl_valid_o));
        check_value({tag, " reg_write"}, 32'd0, 32'(reg_write_o));
        check_value({tag, " mem_write"}, 32'd0, 32'(mem_write_o));
        check_value({tag, " branch"}, 32'd0, 32'(branch_o));
        check_value({tag, " jump"}, 32'd0, 32'(jump_o));
        check_value({tag, " jalr"}, 32'd0, 32'(jalr_o));
        check_value({tag, " illegal"}, 32'(exp_illegal), 32'(illegal_o));
    endtask

    task automatic check_cycle(input logic [31:0] instr, input logic valid, input int idx);
        ctrl_t exp;
        string tag;
        exp = control_row(instr[6:0]);
        tag = $sformatf("instr %0d (%08h)", idx, instr);
        if (!valid)
        begin
            check_idle({tag, " idle"}, last_illegal);
        end
        else
        begin
            check_value({tag, " ctrl_valid"}, 32'd1, 32'(ctrl_valid_o));
            check_value({tag, " reg_write"}, 32'(exp.reg_write), 32'(reg_write_o));
            check_value({tag, " mem_write"}, 32'(exp.mem_write), 32'(mem_write_o));
            check_value({tag, " branch"}, 32'(exp.branch), 32'(branch_o));
            check_value({tag, " jump"}, 32'(exp.jump), 32'(jump_o));
            check_value({tag, " jalr"}, 32'(exp.jalr), 32'(jalr_o));
            check_value({tag, " illegal"}, 32'(exp.illegal), 32'(illegal_o));
            check_value({tag, " funct3"}, 32'(instr[14:12]), 32'(branch_funct3_o));
            check_value({tag, " rd"}, 32'(instr[11:7]), 32'(rd_o));
            check_value({tag, " rs1"}, 32'(instr[19:15]), 32'(rs1_o));
            check_value({tag, " rs2"}, 32'(instr[24:20]), 32'(rs2_o));
            last_illegal = exp.illegal;
            if (!exp.illegal)
            begin
                check_value({tag, " alu_src"}, 32'(exp.alu_src), 32'(alu_src_o));
                check_value({tag, " result_src"}, 32'(exp.result_src), 32'(result_src_o));
                check_value({tag, " pc_alu_a"}, 32'(exp.pc_alu_a), 32'(pc_alu_a_o));
                check_value({tag, " alu_ctrl"},
                            32'(alu_model(exp.alu_op, instr[14:12], instr[30],
                                          instr[6:0] == rv_pkg::OPC_OP)),
                            32'(alu_ctrl_o));
                check_value({tag, " imm"}, imm_model(exp.imm_src, instr), 32'(imm_o));
            end
        end
    endtask

    initial
    begin
        logic [31:0] instr;
        logic        valid;
        lfsr_state    = 32'hcb1e_5c3c;
        last_illegal  = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (RST_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);
        check_idle("after reset", 1'b0);

        // Each instruction is checked one edge after the edge that samples it
        for (int n = 0; n <= NUM_TESTS; n++)
        begin
            @(posedge clk_i);
            if (n < NUM_TESTS)
            begin
                make_instr(instr, valid);
                instr_i       <= instr;
                instr_valid_i <= valid;
                instr_q.push_back(instr);
                valid_q.push_back(valid);
            end
            else
            begin
                instr_valid_i <= 1'b0;
            end
            @(negedge clk_i);
            if (n > 0)
                check_cycle(instr_q.pop_front(), valid_q.pop_front(), n - 1);
        end
        $display("*** PASSED ***");
        $finish;
    end

    initial
    begin
        #(WATCHDOG);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG);
        $display("*** FAILED ***");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== decode_stage.f ====
design/rv_pkg.sv
design/main_decoder.sv
design/alu_decoder.sv
design/imm_extend.sv
design/decode_stage.sv
dv/decode_stage_tb.sv

// ==== Makefile ====
TOP := decode_stage_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f decode_stage.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q -F -- "*** PASSED ***" $(LOG) || { echo "Simulation failed"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
